// File: Makefile
# Verilator build for the sg_alloc testbench

VERILATOR ?= verilator
TOP       ?= tb_sg_alloc
FILELIST  ?= sg_alloc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/buf_alloc_bv.sv
`timescale 1ns/100ps
`default_nettype none

`include "sg_alloc_settings.svh"

module buf_alloc_bv (
    input  wire                         clk,
    input  wire                         reset,
    input  wire sg_alloc_pkg::limit_t   buffer_limit,
    input  wire                         alloc_req,
    input  wire                         dealloc_req,
    input  wire sg_alloc_pkg::ptr_t     dealloc_ptr,
    output logic                        alloc_rdy,
    output sg_alloc_pkg::ptr_t          alloc_ptr
);

    // One bit per buffer, set while the buffer is in use
    logic [`SG_NUM_BUFFERS-1:0] allocated;

    // ----------------------------------------------------------------------
    // Free pointer search
    // ----------------------------------------------------------------------

    // Scan from the top down so the lowest free pointer wins
    // Limit of zero opens the whole vector
    always_comb begin
        alloc_rdy = 1'b0;
        alloc_ptr = '0;
        for (int i = `SG_NUM_BUFFERS - 1; i >= 0; i--) begin
            if (!allocated[i] && (buffer_limit == '0 || i < int'(buffer_limit))) begin
                alloc_rdy = 1'b1;
                alloc_ptr = sg_alloc_pkg::ptr_t'(i);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Allocation vector
    // ----------------------------------------------------------------------

    // Set and clear never hit the same bit, so both may land on one edge
    always_ff @(posedge clk) begin
        if (reset) begin
            allocated <= '0;
        end else begin
            if (dealloc_req) begin
                allocated[dealloc_ptr] <= 1'b0;
            end
            if (alloc_req && alloc_rdy) begin
                allocated[alloc_ptr] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/desc_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "sg_alloc_settings.svh"

module desc_mem (
    input  wire                         clk,
    input  wire                         desc_wr_en,
    input  wire sg_alloc_pkg::ptr_t     desc_wr_addr,
    input  wire sg_alloc_pkg::desc_t    desc_wr_data,
    input  wire                         desc_rd_en,
    input  wire sg_alloc_pkg::ptr_t     desc_rd_addr,
    output sg_alloc_pkg::desc_t         desc_rd_data
);

    // Descriptor per buffer, indexed by buffer pointer
    sg_alloc_pkg::desc_t mem [`SG_NUM_BUFFERS];

    always_ff @(posedge clk) begin
        if (desc_wr_en) begin
            mem[desc_wr_addr] <= desc_wr_data;
        end
    end

    // Registered read, data valid the cycle after desc_rd_en
    always_ff @(posedge clk) begin
        if (desc_rd_en) begin
            desc_rd_data <= mem[desc_rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/sg_alloc_core.sv
`timescale 1ns/100ps
`default_nettype none

module sg_alloc_core (
    input  wire                         clk,
    input  wire                         reset,
    input  wire sg_alloc_pkg::limit_t   buffer_limit,

    // Store beats
    input  wire                         store_valid,
    input  wire sg_alloc_pkg::buf_bytes_t store_bytes,
    input  wire                         store_eof,
    output logic                        store_ack,
    output sg_alloc_pkg::ptr_t          store_ptr,

    // Frame completion
    output logic                        frame_valid,
    output logic                        frame_error,
    output sg_alloc_pkg::ptr_t          frame_ptr,
    output sg_alloc_pkg::frame_size_t   frame_size,

    // Gather
    input  wire                         gather_req,
    input  wire sg_alloc_pkg::ptr_t     gather_ptr,
    output logic                        gather_busy,
    output logic                        load_valid,
    output sg_alloc_pkg::ptr_t          load_ptr,
    output sg_alloc_pkg::buf_bytes_t    load_bytes,
    output logic                        load_eof,

    // Recycle
    input  wire                         recycle_req,
    input  wire sg_alloc_pkg::ptr_t     recycle_ptr,
    output logic                        recycle_done
);

    // ----------------------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------------------

    logic                   alloc_req;
    logic                   alloc_rdy;
    sg_alloc_pkg::ptr_t     alloc_ptr;

    logic                   dealloc_req;
    sg_alloc_pkg::ptr_t     dealloc_ptr;

    logic                   desc_wr_en;
    sg_alloc_pkg::ptr_t     desc_wr_addr;
    sg_alloc_pkg::desc_t    desc_wr_data;

    logic                   desc_rd_en;
    sg_alloc_pkg::ptr_t     desc_rd_addr;
    sg_alloc_pkg::desc_t    desc_rd_data;

    // ----------------------------------------------------------------------
    // Pointer allocator
    // ----------------------------------------------------------------------

    buf_alloc_bv i_buf_alloc_bv (
        .clk,
        .reset,
        .buffer_limit,
        .alloc_req,
        .dealloc_req,
        .dealloc_ptr,
        .alloc_rdy,
        .alloc_ptr
    );

    // ----------------------------------------------------------------------
    // Descriptor memory
    // ----------------------------------------------------------------------

    desc_mem i_desc_mem (
        .clk,
        .desc_wr_en,
        .desc_wr_addr,
        .desc_wr_data,
        .desc_rd_en,
        .desc_rd_addr,
        .desc_rd_data
    );

    // ----------------------------------------------------------------------
    // Scatter and gather
    // ----------------------------------------------------------------------

    sg_scatter i_sg_scatter (
        .clk,
        .reset,
        .store_valid,
        .store_bytes,
        .store_eof,
        .alloc_rdy,
        .alloc_ptr,
        .alloc_req,
        .store_ack,
        .store_ptr,
        .desc_wr_en,
        .desc_wr_addr,
        .desc_wr_data,
        .frame_valid,
        .frame_error,
        .frame_ptr,
        .frame_size
    );

    sg_gather i_sg_gather (
        .clk,
        .reset,
        .gather_req,
        .gather_ptr,
        .recycle_req,
        .recycle_ptr,
        .desc_rd_data,
        .gather_busy,
        .load_valid,
        .load_ptr,
        .load_bytes,
        .load_eof,
        .recycle_done,
        .desc_rd_en,
        .desc_rd_addr,
        .dealloc_req,
        .dealloc_ptr
    );

endmodule

`default_nettype wire

// File: rtl/sg_alloc_pkg.sv
`default_nettype none

`include "sg_alloc_settings.svh"

package sg_alloc_pkg;

    typedef logic [`SG_PTR_WIDTH-1:0]        ptr_t;
    typedef logic [`SG_BYTES_WIDTH-1:0]      buf_bytes_t;
    typedef logic [`SG_FRAME_SIZE_WIDTH-1:0] frame_size_t;

    // One extra bit so the limit can name the full pool, zero means no limit
    typedef logic [`SG_PTR_WIDTH:0]          limit_t;

    // Chain descriptor, one per buffer
    typedef struct packed {
        ptr_t       next_ptr;
        logic       last;
        buf_bytes_t bytes;
    } desc_t;

    typedef enum logic [1:0] {
        walk_idle,
        walk_read,
        walk_present
    } walk_state_t;

endpackage

`default_nettype wire

// File: rtl/sg_alloc_settings.svh
`ifndef SG_ALLOC_SETTINGS_SVH
`define SG_ALLOC_SETTINGS_SVH

// Buffer pool geometry
`define SG_NUM_BUFFERS  16
`define SG_BUFFER_BYTES 64

// Pointer width follows the buffer count
`define SG_PTR_WIDTH ($clog2(`SG_NUM_BUFFERS))

// Per-buffer byte count holds 1 up to a full buffer
`define SG_BYTES_WIDTH ($clog2(`SG_BUFFER_BYTES + 1))

// Largest frame fills every buffer
`define SG_FRAME_SIZE_WIDTH ($clog2(`SG_NUM_BUFFERS * `SG_BUFFER_BYTES + 1))

`endif

// File: rtl/sg_gather.sv
`timescale 1ns/100ps
`default_nettype none

module sg_gather (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         gather_req,
    input  wire sg_alloc_pkg::ptr_t     gather_ptr,
    input  wire                         recycle_req,
    input  wire sg_alloc_pkg::ptr_t     recycle_ptr,
    input  wire sg_alloc_pkg::desc_t    desc_rd_data,
    output logic                        gather_busy,
    output logic                        load_valid,
    output sg_alloc_pkg::ptr_t          load_ptr,
    output sg_alloc_pkg::buf_bytes_t    load_bytes,
    output logic                        load_eof,
    output logic                        recycle_done,
    output logic                        desc_rd_en,
    output sg_alloc_pkg::ptr_t          desc_rd_addr,
    output logic                        dealloc_req,
    output sg_alloc_pkg::ptr_t          dealloc_ptr
);

    sg_alloc_pkg::walk_state_t  state;
    logic                       gather_mode;
    sg_alloc_pkg::ptr_t         cur_ptr;
    logic                       presenting;
    logic                       chain_end;

    assign presenting = (state == sg_alloc_pkg::walk_present);
    assign chain_end  = presenting && desc_rd_data.last;

    // ----------------------------------------------------------------------
    // Outputs decoded from the walker state
    // ----------------------------------------------------------------------

    assign gather_busy  = (state != sg_alloc_pkg::walk_idle);

    assign desc_rd_en   = (state == sg_alloc_pkg::walk_read);
    assign desc_rd_addr = cur_ptr;

    // Each buffer is freed on the cycle its descriptor is back
    assign dealloc_req  = presenting;
    assign dealloc_ptr  = cur_ptr;

    assign load_valid   = presenting && gather_mode;
    assign load_ptr     = cur_ptr;
    assign load_bytes   = desc_rd_data.bytes;
    assign load_eof     = load_valid && desc_rd_data.last;

    assign recycle_done = chain_end && !gather_mode;

    // ----------------------------------------------------------------------
    // Walker FSM
    // ----------------------------------------------------------------------

    // Requests only count in idle, gather takes priority
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= sg_alloc_pkg::walk_idle;
            gather_mode <= 1'b0;
        end else begin
            case (state)
                sg_alloc_pkg::walk_idle: begin
                    if (gather_req) begin
                        gather_mode <= 1'b1;
                        state       <= sg_alloc_pkg::walk_read;
                    end else if (recycle_req) begin
                        gather_mode <= 1'b0;
                        state       <= sg_alloc_pkg::walk_read;
                    end
                end
                sg_alloc_pkg::walk_read: begin
                    state <= sg_alloc_pkg::walk_present;
                end
                sg_alloc_pkg::walk_present: begin
                    if (chain_end) begin
                        state <= sg_alloc_pkg::walk_idle;
                    end else begin
                        state <= sg_alloc_pkg::walk_read;
                    end
                end
                default: begin
                    state <= sg_alloc_pkg::walk_idle;
                end
            endcase
        end
    end

    // Current buffer, loaded from the request then from each next field
    always_ff @(posedge clk) begin
        if (state == sg_alloc_pkg::walk_idle) begin
            cur_ptr <= gather_req ? gather_ptr : recycle_ptr;
        end else if (presenting && !desc_rd_data.last) begin
            cur_ptr <= desc_rd_data.next_ptr;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sg_scatter.sv
`timescale 1ns/100ps
`default_nettype none

module sg_scatter (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         store_valid,
    input  wire sg_alloc_pkg::buf_bytes_t store_bytes,
    input  wire                         store_eof,
    input  wire                         alloc_rdy,
    input  wire sg_alloc_pkg::ptr_t     alloc_ptr,
    output logic                        alloc_req,
    output logic                        store_ack,
    output sg_alloc_pkg::ptr_t          store_ptr,
    output logic                        desc_wr_en,
    output sg_alloc_pkg::ptr_t          desc_wr_addr,
    output sg_alloc_pkg::desc_t         desc_wr_data,
    output logic                        frame_valid,
    output logic                        frame_error,
    output sg_alloc_pkg::ptr_t          frame_ptr,
    output sg_alloc_pkg::frame_size_t   frame_size
);

    logic                       accept;
    logic                       link_wr;

    // Open frame context
    logic                       has_head;
    sg_alloc_pkg::ptr_t         head_ptr;
    sg_alloc_pkg::ptr_t         prev_ptr;
    sg_alloc_pkg::buf_bytes_t   prev_bytes;
    sg_alloc_pkg::frame_size_t  size_acc;
    logic                       frame_err;

    // Context as it stands after the current beat
    logic                       tail_valid;
    sg_alloc_pkg::ptr_t         tail_ptr;
    sg_alloc_pkg::buf_bytes_t   tail_bytes;
    sg_alloc_pkg::ptr_t         head_next;
    sg_alloc_pkg::frame_size_t  size_next;
    logic                       err_next;

    // Pending last-flag write for the closed frame
    logic                       last_wr_q;
    sg_alloc_pkg::ptr_t         last_addr_q;
    sg_alloc_pkg::buf_bytes_t   last_bytes_q;

    assign accept    = store_valid && alloc_rdy;
    assign alloc_req = accept;
    assign link_wr   = accept && has_head;
    assign store_ptr = prev_ptr;

    always_comb begin
        tail_valid = has_head || accept;
        tail_ptr   = accept ? alloc_ptr : prev_ptr;
        tail_bytes = accept ? store_bytes : prev_bytes;
        head_next  = has_head ? head_ptr : alloc_ptr;
        size_next  = size_acc;
        if (accept) begin
            size_next = size_acc + sg_alloc_pkg::frame_size_t'(store_bytes);
        end
        err_next   = frame_err || (store_valid && !alloc_rdy);
    end

    // ----------------------------------------------------------------------
    // Descriptor writes
    // ----------------------------------------------------------------------

    // Links go out with the beat, the last flag on the ack cycle
    // The context is clear after eof, so the two never meet
    assign desc_wr_en = link_wr || last_wr_q;

    always_comb begin
        if (last_wr_q) begin
            desc_wr_addr          = last_addr_q;
            desc_wr_data.next_ptr = '0;
            desc_wr_data.last     = 1'b1;
            desc_wr_data.bytes    = last_bytes_q;
        end else begin
            desc_wr_addr          = prev_ptr;
            desc_wr_data.next_ptr = alloc_ptr;
            desc_wr_data.last     = 1'b0;
            desc_wr_data.bytes    = prev_bytes;
        end
    end

    // ----------------------------------------------------------------------
    // Frame context and completion
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            store_ack   <= 1'b0;
            frame_valid <= 1'b0;
            frame_error <= 1'b0;
            last_wr_q   <= 1'b0;
            has_head    <= 1'b0;
            size_acc    <= '0;
            frame_err   <= 1'b0;
        end else begin
            store_ack   <= accept;
            frame_valid <= store_valid && store_eof;
            last_wr_q   <= store_valid && store_eof && tail_valid;
            if (store_valid && store_eof) begin
                frame_error <= err_next;
                has_head    <= 1'b0;
                size_acc    <= '0;
                frame_err   <= 1'b0;
            end else if (store_valid) begin
                has_head    <= tail_valid;
                size_acc    <= size_next;
                frame_err   <= err_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prev_ptr   <= alloc_ptr;
            prev_bytes <= store_bytes;
            if (!has_head) begin
                head_ptr <= alloc_ptr;
            end
        end
        if (store_valid && store_eof) begin
            frame_ptr    <= head_next;
            frame_size   <= size_next;
            last_addr_q  <= tail_ptr;
            last_bytes_q <= tail_bytes;
        end
    end

endmodule

`default_nettype wire

// File: sg_alloc.f
+incdir+rtl
rtl/sg_alloc_pkg.sv
rtl/buf_alloc_bv.sv
rtl/desc_mem.sv
rtl/sg_scatter.sv
rtl/sg_gather.sv
rtl/sg_alloc_core.sv
tests/sg_alloc_checker.sv
tests/tb_sg_alloc.sv

// File: tests/sg_alloc_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "sg_alloc_settings.svh"

module sg_alloc_checker (
    input  wire                             clk,
    input  wire                             reset,
    input  wire sg_alloc_pkg::limit_t       buffer_limit,
    input  wire                             store_valid,
    input  wire sg_alloc_pkg::buf_bytes_t   store_bytes,
    input  wire                             store_eof,
    input  wire                             store_ack,
    input  wire sg_alloc_pkg::ptr_t         store_ptr,
    input  wire                             frame_valid,
    input  wire                             frame_error,
    input  wire sg_alloc_pkg::ptr_t         frame_ptr,
    input  wire sg_alloc_pkg::frame_size_t  frame_size,
    input  wire                             gather_req,
    input  wire sg_alloc_pkg::ptr_t         gather_ptr,
    input  wire                             recycle_req,
    input  wire sg_alloc_pkg::ptr_t         recycle_ptr,
    input  wire                             gather_busy,
    input  wire                             load_valid,
    input  wire sg_alloc_pkg::ptr_t         load_ptr,
    input  wire sg_alloc_pkg::buf_bytes_t   load_bytes,
    input  wire                             load_eof,
    input  wire                             recycle_done,
    output int                              error_count
);

    localparam int nbuf = `SG_NUM_BUFFERS;

    int errors = 0;

    // Allocator model, one flag per buffer in use
    logic used [nbuf];

    // Frame being stored, pointers as the model hands them out
    int                         cur_len;
    logic                       cur_err;
    sg_alloc_pkg::ptr_t         cur_ptr [nbuf];
    sg_alloc_pkg::buf_bytes_t   cur_bytes [nbuf];

    // Closed chains by head pointer
    int                         chain_len [nbuf];
    sg_alloc_pkg::ptr_t         chain_ptr [nbuf][nbuf];
    sg_alloc_pkg::buf_bytes_t   chain_bytes [nbuf][nbuf];

    // Responses due on the next edge
    logic   exp_ack;
    int     exp_ptr;
    logic   exp_frame;
    logic   exp_err;
    int     exp_size;
    int     exp_len;
    int     exp_head;

    // Walk in progress
    logic   walking;
    logic   walk_gather;
    int     walk_head;
    int     walk_idx;

    assign error_count = errors;

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Lowest free buffer below the limit, -1 when the pool is empty
    function automatic int lowest_free();
        for (int i = 0; i < nbuf; i++) begin
            if (!used[i] && (buffer_limit == 0 || i < int'(buffer_limit))) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Reference frame size, the sum of the accepted beats
    function automatic int frame_sum();
        int sum;
        sum = 0;
        for (int i = 0; i < cur_len; i++) begin
            sum += int'(cur_bytes[i]);
        end
        return sum;
    endfunction

    always @(posedge clk) begin
        int slot;
        if (reset) begin
            for (int i = 0; i < nbuf; i++) begin
                used[i] = 1'b0;
            end
            cur_len   = 0;
            cur_err   = 1'b0;
            exp_ack   = 1'b0;
            exp_frame = 1'b0;
            walking   = 1'b0;
        end else begin
            // ------------------------------------------------------------------
            // Store and frame responses
            // ------------------------------------------------------------------
            check_value("store_ack", int'(exp_ack), int'(store_ack));
            if (exp_ack && store_ack) begin
                check_value("store_ptr", exp_ptr, int'(store_ptr));
            end
            check_value("frame_valid", int'(exp_frame), int'(frame_valid));
            if (exp_frame && frame_valid) begin
                check_value("frame_error", int'(exp_err), int'(frame_error));
                check_value("frame_size", exp_size, int'(frame_size));
                if (exp_len > 0) begin
                    check_value("frame_ptr", exp_head, int'(frame_ptr));
                end
            end
            exp_ack   = 1'b0;
            exp_frame = 1'b0;

            if (store_valid) begin
                slot = lowest_free();
                if (slot >= 0) begin
                    used[slot]         = 1'b1;
                    cur_ptr[cur_len]   = sg_alloc_pkg::ptr_t'(slot);
                    cur_bytes[cur_len] = store_bytes;
                    cur_len++;
                    exp_ack = 1'b1;
                    exp_ptr = slot;
                end else begin
                    cur_err = 1'b1;
                end
                if (store_eof) begin
                    exp_frame = 1'b1;
                    exp_err   = cur_err;
                    exp_size  = frame_sum();
                    exp_len   = cur_len;
                    exp_head  = int'(cur_ptr[0]);
                    if (cur_len > 0) begin
                        chain_len[exp_head] = cur_len;
                        for (int i = 0; i < cur_len; i++) begin
                            chain_ptr[exp_head][i]   = cur_ptr[i];
                            chain_bytes[exp_head][i] = cur_bytes[i];
                        end
                    end
                    cur_len = 0;
                    cur_err = 1'b0;
                end
            end

            // ------------------------------------------------------------------
            // Walk output
            // ------------------------------------------------------------------
            if (walking && !gather_busy) begin
                $display("%0t: gather_busy dropped before the chain was finished", $time);
                errors++;
                walking = 1'b0;
            end

            // Busy must fall on the cycle after the last buffer
            if (!walking && gather_busy) begin
                $display("%0t: gather_busy high with no walk in progress", $time);
                errors++;
            end

            if (load_valid) begin
                if (!walking || !walk_gather) begin
                    $display("%0t: load_valid pulsed with no gather in progress", $time);
                    errors++;
                end else begin
                    check_value("load_ptr", int'(chain_ptr[walk_head][walk_idx]),
                                int'(load_ptr));
                    check_value("load_bytes", int'(chain_bytes[walk_head][walk_idx]),
                                int'(load_bytes));
                    check_value("load_eof", int'(walk_idx == chain_len[walk_head] - 1),
                                int'(load_eof));
                    // Freed on this edge, visible to allocation next cycle
                    used[chain_ptr[walk_head][walk_idx]] = 1'b0;
                    walk_idx++;
                    if (load_eof || walk_idx >= chain_len[walk_head]) begin
                        walking = 1'b0;
                    end
                end
            end

            if (recycle_done) begin
                if (!walking || walk_gather) begin
                    $display("%0t: recycle_done pulsed with no recycle in progress", $time);
                    errors++;
                end else begin
                    for (int i = 0; i < chain_len[walk_head]; i++) begin
                        used[chain_ptr[walk_head][i]] = 1'b0;
                    end
                    walking = 1'b0;
                end
            end

            // New requests only count while idle, gather first
            if (!gather_busy && gather_req) begin
                walking     = 1'b1;
                walk_gather = 1'b1;
                walk_head   = int'(gather_ptr);
                walk_idx    = 0;
            end else if (!gather_busy && recycle_req) begin
                walking     = 1'b1;
                walk_gather = 1'b0;
                walk_head   = int'(recycle_ptr);
                walk_idx    = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_sg_alloc.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sg_alloc;

    // All tests finish in well under a thousand cycles
    localparam int max_cycles = 20000;

    logic                       clk;
    logic                       reset;
    sg_alloc_pkg::limit_t       buffer_limit;
    logic                       store_valid;
    sg_alloc_pkg::buf_bytes_t   store_bytes;
    logic                       store_eof;
    logic                       store_ack;
    sg_alloc_pkg::ptr_t         store_ptr;
    logic                       frame_valid;
    logic                       frame_error;
    sg_alloc_pkg::ptr_t         frame_ptr;
    sg_alloc_pkg::frame_size_t  frame_size;
    logic                       gather_req;
    sg_alloc_pkg::ptr_t         gather_ptr;
    logic                       gather_busy;
    logic                       load_valid;
    sg_alloc_pkg::ptr_t         load_ptr;
    sg_alloc_pkg::buf_bytes_t   load_bytes;
    logic                       load_eof;
    logic                       recycle_req;
    sg_alloc_pkg::ptr_t         recycle_ptr;
    logic                       recycle_done;

    int             error_count;
    int             tb_errors = 0;
    int             cycle_count = 0;
    logic [15:0]    lfsr_state;
    sg_alloc_pkg::ptr_t head_a;
    sg_alloc_pkg::ptr_t head_b;

    sg_alloc_core UUT (
        .clk, .reset, .buffer_limit,
        .store_valid, .store_bytes, .store_eof, .store_ack, .store_ptr,
        .frame_valid, .frame_error, .frame_ptr, .frame_size,
        .gather_req, .gather_ptr, .gather_busy,
        .load_valid, .load_ptr, .load_bytes, .load_eof,
        .recycle_req, .recycle_ptr, .recycle_done
    );

    sg_alloc_checker i_checker (
        .clk, .reset, .buffer_limit,
        .store_valid, .store_bytes, .store_eof, .store_ack, .store_ptr,
        .frame_valid, .frame_error, .frame_ptr, .frame_size,
        .gather_req, .gather_ptr, .recycle_req, .recycle_ptr, .gather_busy,
        .load_valid, .load_ptr, .load_bytes, .load_eof, .recycle_done,
        .error_count
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout after %0d cycles, the DUT never finished the tests", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Random numbers and stimulus helpers
    // ----------------------------------------------------------------------

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic store_frame(input int beats, output sg_alloc_pkg::ptr_t head);
        int nbytes;
        for (int i = 0; i < beats; i++) begin
            draw_bits(6, nbytes);
            store_valid = 1'b1;
            store_bytes = sg_alloc_pkg::buf_bytes_t'(nbytes + 1);
            store_eof   = (i == beats - 1);
            next_cycle();
        end
        store_valid = 1'b0;
        store_eof   = 1'b0;
        while (!frame_valid) begin
            next_cycle();
        end
        head = frame_ptr;
        next_cycle();
    endtask

    task automatic gather_frame(input sg_alloc_pkg::ptr_t head);
        gather_req = 1'b1;
        gather_ptr = head;
        next_cycle();
        gather_req = 1'b0;
        while (gather_busy) begin
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic recycle_frame(input sg_alloc_pkg::ptr_t head);
        recycle_req = 1'b1;
        recycle_ptr = head;
        next_cycle();
        recycle_req = 1'b0;
        while (gather_busy) begin
            next_cycle();
        end
        next_cycle();
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin
        int beats;
        clk          = 1'b0;
        reset        = 1'b1;
        buffer_limit = '0;
        store_valid  = 1'b0;
        store_bytes  = '0;
        store_eof    = 1'b0;
        gather_req   = 1'b0;
        gather_ptr   = '0;
        recycle_req  = 1'b0;
        recycle_ptr  = '0;
        lfsr_state   = 16'd5;
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b0;
        next_cycle();

        // First frame after reset takes pointers from 0 upward
        store_frame(6, head_a);
        gather_frame(head_a);
        repeat (12) begin
            draw_bits(3, beats);
            store_frame(beats % 6 + 1, head_a);
            gather_frame(head_a);
        end

        // Recycle, then the whole pool again
        store_frame(5, head_a);
        recycle_frame(head_a);
        store_frame(16, head_a);
        gather_frame(head_a);

        // Four beats more than the pool holds
        store_frame(20, head_a);
        gather_frame(head_a);

        // Limited pool, then back to all buffers
        buffer_limit = sg_alloc_pkg::limit_t'(8);
        next_cycle();
        store_frame(10, head_a);
        gather_frame(head_a);
        buffer_limit = '0;
        next_cycle();
        store_frame(16, head_a);
        gather_frame(head_a);

        // Second request lands while the first walk is busy
        store_frame(4, head_a);
        store_frame(3, head_b);
        gather_req = 1'b1;
        gather_ptr = head_a;
        next_cycle();
        if (!gather_busy) begin
            $display("%0t: gather_busy stayed low after a gather request", $time);
            tb_errors++;
        end
        gather_ptr = head_b;
        next_cycle();
        gather_req = 1'b0;
        while (gather_busy) begin
            next_cycle();
        end
        next_cycle();
        gather_frame(head_b);

        repeat (4) next_cycle();
        $display("Closing report: %0d checker errors, %0d testbench errors",
                 error_count, tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
